// File: hw/microPkg.sv
// Shared definitions for the microprogrammed calculator
// Microword layout, field codes, bus and host structs, register map

package microPkg;

        typedef struct packed {
                logic [2:0] aluDest;            // Register write select
                logic       carryIn;            // ALU carry in
                logic [4:0] aluFunc;            // ALU function
                logic       bSource;            // B operand select
                logic       aSource;            // A operand select
                logic [3:0] branchOp;           // Sequencer branch operation
                logic       count;              // Step when no jump taken
                logic [7:0] nextAddr;           // Branch target
        } ctrlWord_t;

        localparam logic [2:0] DEST_F     = 3'b011;
        localparam logic [2:0] DEST_TB_TA = 3'b100;
        localparam logic [2:0] DEST_TB    = 3'b101;
        localparam logic [2:0] DEST_TA    = 3'b110;
        localparam logic [2:0] DEST_NONE  = 3'b111;

        localparam logic [4:0] FN_ONES   = 5'b11100;    // FF
        localparam logic [4:0] FN_ZERO   = 5'b10011;    // 00
        localparam logic [4:0] FN_ADD    = 5'b01001;    // A+B+cin
        localparam logic [4:0] FN_SUB    = 5'b00110;    // A+~B+cin
        localparam logic [4:0] FN_DEC    = 5'b01111;    // A-1 with cin set
        localparam logic [4:0] FN_PASS_B = 5'b11010;    // B

        localparam logic SRC_INPUT = 1'b1;              // Latched operand
        localparam logic SRC_TEMP  = 1'b0;              // Temp register

        localparam logic [3:0] BR_COUNT          = 4'b0110;
        localparam logic [3:0] BR_JUMP           = 4'b1110;
        localparam logic [3:0] BR_WAIT_GO        = 4'b0100;
        localparam logic [3:0] BR_WAIT_RELEASE   = 4'b1100;
        localparam logic [3:0] BR_IF_F_ZERO      = 4'b1101;
        localparam logic [3:0] BR_IF_ALU_NONZERO = 4'b1000;
        localparam logic [3:0] BR_DISPATCH       = 4'b1111;

        localparam logic [7:0] ADDR_RESET    = 8'h00;
        localparam logic [7:0] ADDR_IDLE     = 8'h0D;
        localparam logic [7:0] ADDR_ADD_HOLD = 8'h32;
        localparam logic [7:0] ADDR_SUB_HOLD = 8'h72;
        localparam logic [7:0] ADDR_MUL_HOLD = 8'hC6;

        typedef struct packed {
                logic        psel;
                logic        penable;
                logic        pwrite;
                logic [3:0]  paddr;
                logic [31:0] pwdata;
        } apbReq_t;

        typedef struct packed {
                logic       go;                 // Start request
                logic [7:0] opA;
                logic [7:0] opB;
                logic [3:0] opcode;             // Dispatch nibble
        } hostCtrl_t;

        localparam logic [3:0] REG_CTRL     = 4'h0;
        localparam logic [3:0] REG_OPERANDS = 4'h4;
        localparam logic [3:0] REG_RESULT   = 4'h8;
        localparam logic [3:0] REG_STATUS   = 4'hC;

endpackage

// File: hw/controlStore.sv
// Microcode control store
// Fixed 256-word table of 24-bit microinstructions, read combinationally

module controlStore (
        input  logic [7:0]          microAddr,
        output microPkg::ctrlWord_t ctrlWord
);

        always_comb begin
                ctrlWord          = '0;                         // No carry, target 00
                ctrlWord.aluDest  = microPkg::DEST_NONE;
                ctrlWord.aluFunc  = microPkg::FN_ONES;
                ctrlWord.bSource  = microPkg::SRC_INPUT;
                ctrlWord.aSource  = microPkg::SRC_INPUT;
                ctrlWord.branchOp = microPkg::BR_COUNT;
                ctrlWord.count    = 1'b1;
                case (microAddr)
                8'h00: begin                                    // Power-up flashes FF
                        ctrlWord.aluDest  = microPkg::DEST_F;
                        ctrlWord.branchOp = microPkg::BR_JUMP;
                        ctrlWord.nextAddr = 8'h0B;
                end
                8'h0B: ctrlWord.aluDest = microPkg::DEST_TB_TA; // Temps to known FF
                8'h0C: begin                                    // Flash 00
                        ctrlWord.aluDest = microPkg::DEST_F;
                        ctrlWord.aluFunc = microPkg::FN_ZERO;
                end
                microPkg::ADDR_IDLE: begin                      // F shows FF until go
                        ctrlWord.aluDest  = microPkg::DEST_F;
                        ctrlWord.branchOp = microPkg::BR_WAIT_GO;
                        ctrlWord.nextAddr = microPkg::ADDR_IDLE;
                end
                8'h0E: begin                                    // Opcode into high nibble
                        ctrlWord.branchOp = microPkg::BR_DISPATCH;
                        ctrlWord.nextAddr = 8'h01;
                end
                8'h31: begin                                    // F = A + B
                        ctrlWord.aluDest = microPkg::DEST_F;
                        ctrlWord.aluFunc = microPkg::FN_ADD;
                end
                8'h71: begin                                    // F = A - B
                        ctrlWord.aluDest = microPkg::DEST_F;
                        ctrlWord.aluFunc = microPkg::FN_SUB;
                        ctrlWord.carryIn = 1'b1;
                end
                microPkg::ADDR_ADD_HOLD, microPkg::ADDR_SUB_HOLD: begin
                        ctrlWord.branchOp = microPkg::BR_WAIT_RELEASE;  // Keep F
                        ctrlWord.nextAddr = microAddr;
                end
                8'h33, 8'h73, 8'hC7: begin                      // Flash 00, back to idle
                        ctrlWord.aluDest  = microPkg::DEST_F;
                        ctrlWord.aluFunc  = microPkg::FN_ZERO;
                        ctrlWord.branchOp = microPkg::BR_JUMP;
                        ctrlWord.nextAddr = microPkg::ADDR_IDLE;
                end
                8'hC1: begin                                    // Clear product
                        ctrlWord.aluDest = microPkg::DEST_TB;
                        ctrlWord.aluFunc = microPkg::FN_ZERO;
                end
                8'hC2: begin                                    // F = B for zero test
                        ctrlWord.aluDest = microPkg::DEST_F;
                        ctrlWord.aluFunc = microPkg::FN_PASS_B;
                end
                8'hC3: begin                                    // TA = B, skip loop if B is 0
                        ctrlWord.aluDest  = microPkg::DEST_TA;
                        ctrlWord.aluFunc  = microPkg::FN_PASS_B;
                        ctrlWord.branchOp = microPkg::BR_IF_F_ZERO;
                        ctrlWord.nextAddr = microPkg::ADDR_MUL_HOLD;
                end
                8'hC4: begin                                    // TB = A + TB
                        ctrlWord.aluDest = microPkg::DEST_TB;
                        ctrlWord.aluFunc = microPkg::FN_ADD;
                        ctrlWord.bSource = microPkg::SRC_TEMP;
                end
                8'hC5: begin                                    // TA = TA - 1, loop while nonzero
                        ctrlWord.aluDest  = microPkg::DEST_TA;
                        ctrlWord.aluFunc  = microPkg::FN_DEC;
                        ctrlWord.carryIn  = 1'b1;
                        ctrlWord.aSource  = microPkg::SRC_TEMP;
                        ctrlWord.bSource  = microPkg::SRC_TEMP;
                        ctrlWord.branchOp = microPkg::BR_IF_ALU_NONZERO;
                        ctrlWord.nextAddr = 8'hC4;
                end
                microPkg::ADDR_MUL_HOLD: begin                  // F = product until release
                        ctrlWord.aluDest  = microPkg::DEST_F;
                        ctrlWord.aluFunc  = microPkg::FN_PASS_B;
                        ctrlWord.bSource  = microPkg::SRC_TEMP;
                        ctrlWord.branchOp = microPkg::BR_WAIT_RELEASE;
                        ctrlWord.nextAddr = microPkg::ADDR_MUL_HOLD;
                end
                default: begin                                  // Unused word restarts power-up
                        ctrlWord.aluDest  = microPkg::DEST_F;
                        ctrlWord.branchOp = microPkg::BR_JUMP;
                        ctrlWord.nextAddr = microPkg::ADDR_RESET;
                end
                endcase
        end

endmodule

// File: hw/microSequencer.sv
// Micro program counter
// Picks step, branch or opcode dispatch from the branch field and flags

module microSequencer (
        input  logic                clk,
        input  logic                rst,
        input  microPkg::ctrlWord_t ctrlWord,
        input  microPkg::hostCtrl_t hostCtrl,
        input  logic                fZero,
        input  logic                aluNonZero,
        output logic [7:0]          microAddr,
        output logic                loadInputs
);

        logic       jump;                               // Branch to nextAddr
        logic       dispatch;                           // Branch on opcode
        logic [7:0] addrNext;

        always_comb begin
                jump     = 1'b0;
                dispatch = 1'b0;
                case (ctrlWord.branchOp)
                microPkg::BR_JUMP:           jump = 1'b1;
                microPkg::BR_WAIT_GO:        jump = !hostCtrl.go;
                microPkg::BR_WAIT_RELEASE:   jump = hostCtrl.go;
                microPkg::BR_IF_F_ZERO:      jump = fZero;
                microPkg::BR_IF_ALU_NONZERO: jump = aluNonZero;
                microPkg::BR_DISPATCH:       dispatch = 1'b1;
                default:                     jump = 1'b0;       // Plain count
                endcase
        end

        always_comb begin
                if (dispatch) begin
                        addrNext = {hostCtrl.opcode, ctrlWord.nextAddr[3:0]};
                end else if (jump) begin
                        addrNext = ctrlWord.nextAddr;
                end else if (ctrlWord.count) begin
                        addrNext = microAddr + 8'd1;
                end else begin
                        addrNext = microAddr;           // Stall
                end
        end

        assign loadInputs = dispatch;                   // Latch operands on dispatch

        always_ff @(posedge clk) begin
                if (rst) begin
                        microAddr <= microPkg::ADDR_RESET;
                end else begin
                        microAddr <= addrNext;
                end
        end

endmodule

// File: hw/aluDatapath.sv
// Calculator datapath
// Input latches, temp registers A and B, ALU and output register F

module aluDatapath (
        input  logic                clk,
        input  logic                rst,
        input  microPkg::ctrlWord_t ctrlWord,
        input  microPkg::hostCtrl_t hostCtrl,
        input  logic                loadInputs,
        output logic [7:0]          result,
        output logic                fZero,
        output logic                aluNonZero
);

        logic [7:0] inA;                                // Latched operands
        logic [7:0] inB;
        logic [7:0] tempA;
        logic [7:0] tempB;
        logic [7:0] regF;
        logic [7:0] aluA;
        logic [7:0] aluB;
        logic [7:0] aluOut;

        assign aluA = (ctrlWord.aSource == microPkg::SRC_INPUT) ? inA : tempA;
        assign aluB = (ctrlWord.bSource == microPkg::SRC_INPUT) ? inB : tempB;

        always_comb begin
                case (ctrlWord.aluFunc)
                microPkg::FN_ZERO:   aluOut = 8'h00;
                microPkg::FN_ADD:    aluOut = aluA + aluB + 8'(ctrlWord.carryIn);
                microPkg::FN_SUB:    aluOut = aluA + ~aluB + 8'(ctrlWord.carryIn);
                microPkg::FN_DEC:    aluOut = aluA + 8'hFE + 8'(ctrlWord.carryIn);
                microPkg::FN_PASS_B: aluOut = aluB;
                default:             aluOut = 8'hFF;    // FN_ONES and unused codes
                endcase
        end

        always_ff @(posedge clk) begin
                if (rst) begin
                        inA   <= 8'h00;
                        inB   <= 8'h00;
                        tempA <= 8'h00;
                        tempB <= 8'h00;
                        regF  <= 8'h00;
                end else begin
                        if (loadInputs) begin
                                inA <= hostCtrl.opA;
                                inB <= hostCtrl.opB;
                        end
                        case (ctrlWord.aluDest)
                        microPkg::DEST_F: regF <= aluOut;
                        microPkg::DEST_TB_TA: begin
                                tempA <= aluOut;
                                tempB <= aluOut;
                        end
                        microPkg::DEST_TB: tempB <= aluOut;
                        microPkg::DEST_TA: tempA <= aluOut;
                        default: ;                      // DEST_NONE
                        endcase
                end
        end

        assign result     = regF;
        assign fZero      = (regF == 8'h00);
        assign aluNonZero = |aluOut;                    // Loop test in multiply

endmodule

// File: hw/apbRegs.sv
// APB register block
// Holds go, operands and opcode; reads back result and microaddress

module apbRegs (
        input  logic                clk,
        input  logic                rst,
        input  microPkg::apbReq_t   apbReq,
        output logic [31:0]         prdata,
        output logic                pready,
        output logic                pslverr,
        output microPkg::hostCtrl_t hostCtrl,
        input  logic [7:0]          result,
        input  logic [7:0]          microAddr
);

        logic access;                                   // Access phase without wait states
        logic validAddr;

        assign access = apbReq.psel && apbReq.penable;
        assign pready = 1'b1;

        always_comb begin
                validAddr = 1'b1;
                case (apbReq.paddr)
                microPkg::REG_CTRL:     prdata = {31'd0, hostCtrl.go};
                microPkg::REG_OPERANDS: begin
                        prdata = {12'd0, hostCtrl.opcode, hostCtrl.opB, hostCtrl.opA};
                end
                microPkg::REG_RESULT:   prdata = {24'd0, result};
                microPkg::REG_STATUS:   prdata = {24'd0, microAddr};
                default: begin
                        prdata    = 32'd0;
                        validAddr = 1'b0;
                end
                endcase
        end

        assign pslverr = access && !validAddr;

        always_ff @(posedge clk) begin
                if (rst) begin
                        hostCtrl <= '0;
                end else if (access && apbReq.pwrite) begin
                        case (apbReq.paddr)
                        microPkg::REG_CTRL: hostCtrl.go <= apbReq.pwdata[0];
                        microPkg::REG_OPERANDS: begin
                                hostCtrl.opA    <= apbReq.pwdata[7:0];
                                hostCtrl.opB    <= apbReq.pwdata[15:8];
                                hostCtrl.opcode <= apbReq.pwdata[19:16];
                        end
                        default: ;                      // Read-only or unmapped
                        endcase
                end
        end

endmodule

// File: hw/microCpuTop.sv
// Microprogrammed calculator top level
// APB registers beside sequencer, control store and datapath

module microCpuTop (
        input  logic              clk,
        input  logic              rst,
        input  microPkg::apbReq_t apbReq,
        output logic [31:0]       prdata,
        output logic              pready,
        output logic              pslverr
);

        microPkg::hostCtrl_t hostCtrl;
        microPkg::ctrlWord_t ctrlWord;
        logic [7:0]          microAddr;
        logic [7:0]          result;
        logic                loadInputs;
        logic                fZero;
        logic                aluNonZero;

        apbRegs uApbRegs (
                .clk       (clk),
                .rst       (rst),
                .apbReq    (apbReq),
                .prdata    (prdata),
                .pready    (pready),
                .pslverr   (pslverr),
                .hostCtrl  (hostCtrl),
                .result    (result),
                .microAddr (microAddr)
        );

        microSequencer uSequencer (
                .clk        (clk),
                .rst        (rst),
                .ctrlWord   (ctrlWord),
                .hostCtrl   (hostCtrl),
                .fZero      (fZero),
                .aluNonZero (aluNonZero),
                .microAddr  (microAddr),
                .loadInputs (loadInputs)
        );

        controlStore uStore (
                .microAddr (microAddr),
                .ctrlWord  (ctrlWord)
        );

        aluDatapath uDatapath (
                .clk        (clk),
                .rst        (rst),
                .ctrlWord   (ctrlWord),
                .hostCtrl   (hostCtrl),
                .loadInputs (loadInputs),
                .result     (result),
                .fZero      (fZero),
                .aluNonZero (aluNonZero)
        );

endmodule

// File: dv/microCpuTb.sv
// Directed testbench for the microprogrammed calculator
// Drives operations over APB and checks result and microaddress

module microCpuTb;

        localparam int DRIVE_DELAY = 10;                // After rising edge
        localparam int POLL_LIMIT  = 300;               // Status reads per wait
        localparam int READY_LIMIT = 16;                // Cycles for pready

        logic              clk;
        logic              rst;
        microPkg::apbReq_t apbReq;
        logic [31:0]       prdata;
        logic              pready;
        logic              pslverr;
        int                errorCount;
        int                checkCount;
        logic              timedOut;                    // Skips later tests

        microCpuTop dut (
                .clk     (clk),
                .rst     (rst),
                .apbReq  (apbReq),
                .prdata  (prdata),
                .pready  (pready),
                .pslverr (pslverr)
        );

        always #50 clk = ~clk;

        task automatic checkValue(input string name, input logic [31:0] actual,
                                  input logic [31:0] expected);
                checkCount++;
                if (actual !== expected) begin
                        errorCount++;
                        $display("[FAIL] %s: got %h, expected %h", name, actual, expected);
                end
        endtask

        // Setup, access, then back to idle; data sampled at the falling edge
        task automatic apbTransfer(input logic write, input logic [3:0] addr,
                                   input logic [31:0] wdata, output logic [31:0] rdata,
                                   output logic err);
                int waitCount;
                waitCount = 0;
                @(posedge clk);
                #DRIVE_DELAY;
                apbReq.psel    = 1'b1;
                apbReq.penable = 1'b0;
                apbReq.pwrite  = write;
                apbReq.paddr   = addr;
                apbReq.pwdata  = wdata;
                @(posedge clk);
                #DRIVE_DELAY;
                apbReq.penable = 1'b1;                  // Access phase
                @(negedge clk);
                while (pready !== 1'b1 && waitCount < READY_LIMIT) begin
                        @(negedge clk);
                        waitCount++;
                end
                if (pready !== 1'b1) begin
                        errorCount++;
                        timedOut = 1'b1;
                        $display("APB transfer to offset %h never saw pready", addr);
                end
                rdata = prdata;
                err   = pslverr;
                @(posedge clk);
                #DRIVE_DELAY;
                apbReq = '0;
        endtask

        task automatic apbWrite(input logic [3:0] addr, input logic [31:0] data);
                logic [31:0] unused;
                logic        err;
                apbTransfer(1'b1, addr, data, unused, err);
                checkValue("pslverr on write", {31'd0, err}, 32'd0);
        endtask

        task automatic apbRead(input logic [3:0] addr, output logic [31:0] data);
                logic err;
                apbTransfer(1'b0, addr, 32'd0, data, err);
                checkValue("pslverr on read", {31'd0, err}, 32'd0);
        endtask

        task automatic pollStatus(input logic [7:0] target);
                logic [31:0] status;
                int          polls;
                polls = 0;
                apbRead(microPkg::REG_STATUS, status);
                while (status[7:0] !== target && polls < POLL_LIMIT) begin
                        apbRead(microPkg::REG_STATUS, status);
                        polls++;
                end
                if (status[7:0] !== target) begin
                        errorCount++;
                        timedOut = 1'b1;
                        $display("Timed out waiting for microaddress %h, last %h",
                                 target, status[7:0]);
                end
        endtask

        // Any of 00, 0B, 0C shows up within one pass of the restart loop
        task automatic waitPowerUp();
                logic [31:0] status;
                int          polls;
                polls = 0;
                apbRead(microPkg::REG_STATUS, status);
                while (!(status[7:0] inside {8'h00, 8'h0B, 8'h0C}) && polls < POLL_LIMIT) begin
                        apbRead(microPkg::REG_STATUS, status);
                        polls++;
                end
                if (!(status[7:0] inside {8'h00, 8'h0B, 8'h0C})) begin
                        errorCount++;
                        timedOut = 1'b1;
                        $display("Unused opcode never reached the power-up sequence");
                end
        endtask

        task automatic runOperation(input logic [3:0] opcode, input logic [7:0] a,
                                    input logic [7:0] b, input logic [7:0] hold,
                                    input logic [7:0] expected, input string name);
                logic [31:0] value;
                apbWrite(microPkg::REG_OPERANDS, {12'd0, opcode, b, a});
                apbWrite(microPkg::REG_CTRL, 32'd1);            // Go
                pollStatus(hold);
                if (timedOut) return;
                apbRead(microPkg::REG_RESULT, value);
                checkValue(name, value, {24'd0, expected});
                apbWrite(microPkg::REG_CTRL, 32'd0);            // Release
                pollStatus(microPkg::ADDR_IDLE);
                if (timedOut) return;
                apbRead(microPkg::REG_RESULT, value);
                checkValue("result at idle", value, 32'h0000_00FF);
        endtask

        task automatic testReset();
                logic [31:0] value;
                pollStatus(microPkg::ADDR_IDLE);
                if (timedOut) return;
                apbRead(microPkg::REG_RESULT, value);
                checkValue("result after power-up", value, 32'h0000_00FF);
                apbRead(microPkg::REG_CTRL, value);
                checkValue("ctrl after reset", value, 32'd0);
                apbRead(microPkg::REG_OPERANDS, value);
                checkValue("operands after reset", value, 32'd0);
        endtask

        task automatic testArith(input logic [3:0] opcode, input logic [7:0] hold,
                                 input string name);
                logic [7:0] a[8];
                logic [7:0] b[8];
                logic [7:0] expected;
                a = '{8'h00, 8'hFF, 8'h80, 8'h12, 8'h03, 8'h00, 8'h01, 8'hFF};
                b = '{8'h00, 8'h01, 8'h80, 8'h34, 8'h05, 8'h01, 8'h00, 8'hFF};
                for (int i = 0; i < 12 && !timedOut; i++) begin
                        if (i >= 8) begin                       // Random pairs
                                a[i % 8] = 8'($urandom % 256);
                                b[i % 8] = 8'($urandom % 256);
                        end
                        if (opcode == 4'h3) expected = a[i % 8] + b[i % 8];
                        else expected = a[i % 8] - b[i % 8];    // Wraps on borrow
                        runOperation(opcode, a[i % 8], b[i % 8], hold, expected, name);
                end
        endtask

        task automatic testMultiply();
                logic [7:0] a[4];
                logic [7:0] b[4];
                logic [7:0] opA;
                logic [7:0] opB;
                logic [7:0] expected;
                a = '{8'h07, 8'h09, 8'h00, 8'hFF};              // Last pair wraps
                b = '{8'h00, 8'h01, 8'h05, 8'h02};              // B of 0 skips the loop
                for (int i = 0; i < 10 && !timedOut; i++) begin
                        if (i < 4) begin
                                opA = a[i];
                                opB = b[i];
                        end else begin
                                opA = 8'($urandom % 256);
                                opB = 8'($urandom % 16);        // Small loop count
                        end
                        expected = opA * opB;
                        runOperation(4'hC, opA, opB, microPkg::ADDR_MUL_HOLD, expected,
                                     "product");
                end
        endtask

        task automatic testOperandHold();
                logic [31:0] value;
                apbWrite(microPkg::REG_OPERANDS, {12'd0, 4'h3, 8'h22, 8'h11});
                apbWrite(microPkg::REG_CTRL, 32'd1);
                pollStatus(microPkg::ADDR_ADD_HOLD);
                if (timedOut) return;
                apbWrite(microPkg::REG_OPERANDS, {12'd0, 4'h3, 8'hBB, 8'hAA});
                apbRead(microPkg::REG_STATUS, value);
                checkValue("status while held", value, 32'h0000_0032);
                apbRead(microPkg::REG_RESULT, value);
                checkValue("held sum", value, 32'h0000_0033);
                apbWrite(microPkg::REG_CTRL, 32'd0);
                pollStatus(microPkg::ADDR_IDLE);
        endtask

        task automatic testErrors();
                logic [31:0] value;
                logic        err;
                apbWrite(microPkg::REG_OPERANDS, {12'd0, 4'h5, 8'h44, 8'h33});
                apbTransfer(1'b0, 4'h2, 32'd0, value, err);
                checkValue("pslverr at offset 2", {31'd0, err}, 32'd1);
                apbTransfer(1'b1, 4'h6, 32'hFFFF_FFFF, value, err);
                checkValue("pslverr at offset 6", {31'd0, err}, 32'd1);
                apbTransfer(1'b1, 4'hF, 32'hFFFF_FFFF, value, err);
                checkValue("pslverr at offset F", {31'd0, err}, 32'd1);
                apbRead(microPkg::REG_OPERANDS, value);
                checkValue("operands after bad writes", value, 32'h0005_4433);
                apbWrite(microPkg::REG_CTRL, 32'd1);            // Opcode 5 is unused
                waitPowerUp();
                if (timedOut) return;
                apbWrite(microPkg::REG_CTRL, 32'd0);
                pollStatus(microPkg::ADDR_IDLE);
                if (timedOut) return;
                apbRead(microPkg::REG_RESULT, value);
                checkValue("result after restart", value, 32'h0000_00FF);
        endtask

        initial begin
                clk        = 1'b0;
                rst        = 1'b1;
                apbReq     = '0;
                errorCount = 0;
                checkCount = 0;
                timedOut   = 1'b0;
                void'($urandom(32'hf51d));
                repeat (4) @(posedge clk);
                #DRIVE_DELAY;
                rst = 1'b0;
                testReset();
                if (!timedOut) testArith(4'h3, microPkg::ADDR_ADD_HOLD, "sum");
                if (!timedOut) testArith(4'h7, microPkg::ADDR_SUB_HOLD, "difference");
                if (!timedOut) testMultiply();
                if (!timedOut) testOperandHold();
                if (!timedOut) testErrors();
                $display("Checks: %0d, errors: %0d", checkCount, errorCount);
                if (errorCount == 0) begin
                        $display("No errors");
                end else begin
                        $display("Errors found");
                end
                $finish;
        end

endmodule

// File: sources.f
hw/microPkg.sv
hw/controlStore.sv
hw/microSequencer.sv
hw/aluDatapath.sv
hw/apbRegs.sv
hw/microCpuTop.sv
dv/microCpuTb.sv

// File: Makefile
# Verilator build and run for the microprogrammed calculator

VERILATOR ?= verilator
TOP       ?= microCpuTb
FILELIST  ?= sources.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0
PASS_TEXT ?= No errors

SOURCES := $(shell cat $(FILELIST))
BINARY  := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(BINARY)

$(BINARY): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(BINARY) | tee $(LOG)
	@grep -qx "$(PASS_TEXT)" $(LOG) || (echo "Simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
